/* src/br_pkg.sv */
`default_nettype none

// Shared constants and types for the branch path
package br_pkg;

  // Datapath width used unless the top level overrides it
  localparam int OPERAND_WIDTH_DEF = 32;

  // First fetch address after reset, word aligned
  localparam logic [OPERAND_WIDTH_DEF-1:0] RESET_PC_DEF = 32'h0000_0100;

  // Major opcode lives in insn[31:26]
  localparam int OPCODE_WIDTH = 6;

  // Major opcodes handled by the branch path
  // l.j, unconditional pc-relative jump
  localparam logic [OPCODE_WIDTH-1:0] OPC_J   = 6'h00;
  // l.bnf, taken when flag is clear
  localparam logic [OPCODE_WIDTH-1:0] OPC_BNF = 6'h03;
  // l.bf, taken when flag is set
  localparam logic [OPCODE_WIDTH-1:0] OPC_BF  = 6'h04;
  // l.jr, register-indirect jump resolved in execute
  localparam logic [OPCODE_WIDTH-1:0] OPC_JR  = 6'h11;

  // Immediate field of l.j / l.bf / l.bnf, in words
  localparam int OFFSET_WIDTH = 26;

  // Kind of branch found by the decode stage
  typedef enum logic [1:0] {
    BR_NONE       = 2'd0,
    BR_JUMP       = 2'd1,
    BR_IF_FLAG    = 2'd2,
    BR_IF_NO_FLAG = 2'd3
  } br_kind_e;

endpackage

`default_nettype wire

/* src/br_decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decode stage to branch controller
interface br_decode_if
  import br_pkg::*;
#(
  parameter int OPERAND_WIDTH = OPERAND_WIDTH_DEF
) ();

  // Taken immediate branch in decode
  logic                     branch;
  // PC-relative target of that branch
  logic [OPERAND_WIDTH-1:0] target;
  // Decode advances this cycle
  logic                     padv;
  // Nothing valid in decode
  logic                     bubble;

  modport decode (output branch, output target, output padv, output bubble);
  modport ctrl   (input  branch, input  target, input  padv, input  bubble);

endinterface

`default_nettype wire

/* src/br_decode.sv */
`timescale 1ns/1ps
`default_nettype none

// Decode-stage branch recogniser
// Resolves l.j / l.bf / l.bnf and builds the immediate target
module br_decode
  import br_pkg::*;
#(
  parameter int OPERAND_WIDTH = OPERAND_WIDTH_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              insn_i,
  input  logic                     insn_valid_i,
  input  logic                     padv_i,
  input  logic                     flag_i,
  input  logic [OPERAND_WIDTH-1:0] pc_i,
  br_decode_if.decode              dec
);

  logic [OPCODE_WIDTH-1:0]  opc;
  br_kind_e                 kind;
  logic                     taken;
  logic [OPERAND_WIDTH-1:0] offset_sext;

  // Major opcode field
  assign opc = insn_i[31 -: OPCODE_WIDTH];

  // Classify opcode
  always_comb begin
    case (opc)
      OPC_J:   kind = BR_JUMP;
      OPC_BF:  kind = BR_IF_FLAG;
      OPC_BNF: kind = BR_IF_NO_FLAG;
      default: kind = BR_NONE;
    endcase
  end

  // Conditional branches resolved against current flag
  always_comb begin
    case (kind)
      BR_JUMP:       taken = 1'b1;
      BR_IF_FLAG:    taken = flag_i;
      BR_IF_NO_FLAG: taken = ~flag_i;
      default:       taken = 1'b0;
    endcase
  end

  // Word offset, sign extended to operand width
  assign offset_sext = {{(OPERAND_WIDTH-OFFSET_WIDTH){insn_i[OFFSET_WIDTH-1]}},
                        insn_i[OFFSET_WIDTH-1:0]};

  // Only a valid instruction can branch
  assign dec.branch = insn_valid_i & taken;
  // Byte target relative to the decode PC
  assign dec.target = pc_i + (offset_sext << 2);
  assign dec.padv   = padv_i;
  assign dec.bubble = ~insn_valid_i;

  // Immediate target inherits the alignment of the decode PC from fetch
  a_imm_target_aligned : assert property (
    @(posedge clk) disable iff (rst)
    dec.branch |-> dec.target[1:0] == 2'b00
  );

endmodule

`default_nettype wire

/* src/br_exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// Execute-stage opcode register
// Holds l.jr indication and checks its target alignment
module br_exec_stage
  import br_pkg::*;
#(
  parameter int OPERAND_WIDTH = OPERAND_WIDTH_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush_i,
  input  logic                     padv_i,
  input  logic [31:0]              insn_i,
  input  logic                     insn_valid_i,
  input  logic [OPERAND_WIDTH-1:0] rfb_i,
  output logic                     op_jr_o,
  output logic [OPCODE_WIDTH-1:0]  opc_o,
  output logic                     ibus_align_o
);

  logic [OPCODE_WIDTH-1:0] dec_opc;

  assign dec_opc = insn_i[31 -: OPCODE_WIDTH];

  // Opcode and jr flag move from decode on advance
  // Bubble or flush leaves execute empty
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      op_jr_o <= 1'b0;
      opc_o   <= '0;
    end else if (padv_i) begin
      if (!insn_valid_i) begin
        op_jr_o <= 1'b0;
        opc_o   <= '0;
      end else begin
        op_jr_o <= (dec_opc == OPC_JR);
        opc_o   <= dec_opc;
      end
    end
  end

  // l.jr target must be word aligned
  // rfb_i is the operand read for the instruction now in execute
  assign ibus_align_o = op_jr_o & (|rfb_i[1:0]);

endmodule

`default_nettype wire

/* src/br_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// Branch controller
// Merges exception, immediate and l.jr redirects into one occur level
module br_ctrl
  import br_pkg::*;
#(
  parameter int OPERAND_WIDTH = OPERAND_WIDTH_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush_i,
  br_decode_if.ctrl                dec,
  input  logic                     op_jr_i,
  input  logic [OPCODE_WIDTH-1:0]  opc_i,
  input  logic                     flag_i,
  input  logic                     ibus_align_i,
  input  logic                     except_i,
  input  logic [OPERAND_WIDTH-1:0] except_pc_i,
  input  logic [OPERAND_WIDTH-1:0] rfb_i,
  output logic                     branch_occur_o,
  output logic [OPERAND_WIDTH-1:0] branch_target_o
);

  logic                     imm_branch;
  logic [OPERAND_WIDTH-1:0] imm_target;
  logic                     occur_q;
  logic [OPERAND_WIDTH-1:0] target_q;
  logic                     new_branch;
  logic [OPERAND_WIDTH-1:0] target_mux;

  // Decode branch moved into execute so all sources line up
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      imm_branch <= 1'b0;
    end else if (dec.padv) begin
      imm_branch <= dec.branch & ~dec.bubble;
    end
  end

  // Target follows the branch bit
  always_ff @(posedge clk) begin
    if (dec.padv) begin
      imm_target <= dec.target;
    end
  end

  // Exception wins over everything
  // Misaligned l.jr suppressed only on its first cycle
  assign branch_occur_o = except_i | imm_branch |
                          (op_jr_i & ~(ibus_align_i & ~occur_q));

  // Priority: exception, immediate, register
  assign target_mux = except_i   ? except_pc_i :
                      imm_branch ? imm_target  :
                      rfb_i;

  // Rising edge of occur
  assign new_branch = branch_occur_o & ~occur_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      occur_q <= 1'b0;
    end else begin
      occur_q <= branch_occur_o;
    end
  end

  // Capture target on a new branch
  // rfb_i may change on the next cycle, so hold it here
  always_ff @(posedge clk) begin
    if (new_branch) begin
      target_q <= target_mux;
    end
  end

  assign branch_target_o = new_branch ? target_mux : target_q;

  // Held target must not move while occur stays up
  a_target_held : assert property (
    @(posedge clk) disable iff (rst)
    (branch_occur_o && $past(branch_occur_o) && !except_i)
      |-> $stable(branch_target_o)
  );

  // Conditional branch entering execute agrees with the flag seen in decode
  a_bf_flag : assert property (
    @(posedge clk) disable iff (rst)
    (imm_branch && $past(dec.padv) && !$past(flush_i) && opc_i == OPC_BF)
      |-> $past(flag_i)
  );

  a_bnf_flag : assert property (
    @(posedge clk) disable iff (rst)
    (imm_branch && $past(dec.padv) && !$past(flush_i) && opc_i == OPC_BNF)
      |-> !$past(flag_i)
  );

endmodule

`default_nettype wire

/* src/fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

// Fetch program counter
// Redirects on a new branch, else steps one word per advance
module fetch_pc
  import br_pkg::*;
#(
  parameter int                     OPERAND_WIDTH = OPERAND_WIDTH_DEF,
  parameter logic [OPERAND_WIDTH-1:0] RESET_PC    = RESET_PC_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     padv_i,
  input  logic                     branch_occur_i,
  input  logic [OPERAND_WIDTH-1:0] branch_target_i,
  output logic [OPERAND_WIDTH-1:0] pc_o
);

  logic occur_q;
  logic new_branch;

  // Local edge detect, occur can stay high for several cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      occur_q <= 1'b0;
    end else begin
      occur_q <= branch_occur_i;
    end
  end

  assign new_branch = branch_occur_i & ~occur_q;

  // Redirect takes effect even while stalled
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= RESET_PC;
    end else if (new_branch) begin
      pc_o <= branch_target_i;
    end else if (padv_i) begin
      pc_o <= pc_o + OPERAND_WIDTH'(4);
    end
  end

  // Alignment kept unless a redirect brings a misaligned target
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (rst)
    (pc_o[1:0] == 2'b00 && !(new_branch && |branch_target_i[1:0]))
      |=> pc_o[1:0] == 2'b00
  );

endmodule

`default_nettype wire

/* src/branch_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Branch path top level
// Decode, execute, branch controller and fetch PC
module branch_subsys_top
  import br_pkg::*;
#(
  parameter int                       OPERAND_WIDTH = OPERAND_WIDTH_DEF,
  parameter logic [OPERAND_WIDTH-1:0] RESET_PC      = RESET_PC_DEF
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush_i,
  input  logic                     padv_i,
  input  logic [31:0]              insn_i,
  input  logic                     insn_valid_i,
  input  logic                     flag_i,
  input  logic [OPERAND_WIDTH-1:0] rfb_i,
  input  logic                     except_i,
  input  logic [OPERAND_WIDTH-1:0] except_pc_i,
  output logic [OPERAND_WIDTH-1:0] pc_o,
  output logic                     branch_occur_o,
  output logic [OPERAND_WIDTH-1:0] branch_target_o
);

  logic                    op_jr;
  logic [OPCODE_WIDTH-1:0] exec_opc;
  logic                    ibus_align;

  // Decode to controller bundle
  br_decode_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) dec_if ();

  br_decode #(.OPERAND_WIDTH(OPERAND_WIDTH)) i_br_decode (
    .clk          (clk),
    .rst          (rst),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .padv_i       (padv_i),
    .flag_i       (flag_i),
    .pc_i         (pc_o),
    .dec          (dec_if.decode)
  );

  br_exec_stage #(.OPERAND_WIDTH(OPERAND_WIDTH)) i_br_exec_stage (
    .clk          (clk),
    .rst          (rst),
    .flush_i      (flush_i),
    .padv_i       (padv_i),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .rfb_i        (rfb_i),
    .op_jr_o      (op_jr),
    .opc_o        (exec_opc),
    .ibus_align_o (ibus_align)
  );

  br_ctrl #(.OPERAND_WIDTH(OPERAND_WIDTH)) i_br_ctrl (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .dec             (dec_if.ctrl),
    .op_jr_i         (op_jr),
    .opc_i           (exec_opc),
    .flag_i          (flag_i),
    .ibus_align_i    (ibus_align),
    .except_i        (except_i),
    .except_pc_i     (except_pc_i),
    .rfb_i           (rfb_i),
    .branch_occur_o  (branch_occur_o),
    .branch_target_o (branch_target_o)
  );

  // Fetch follows the controller redirect
  fetch_pc #(
    .OPERAND_WIDTH (OPERAND_WIDTH),
    .RESET_PC      (RESET_PC)
  ) i_fetch_pc (
    .clk             (clk),
    .rst             (rst),
    .padv_i          (padv_i),
    .branch_occur_i  (branch_occur_o),
    .branch_target_i (branch_target_o),
    .pc_o            (pc_o)
  );

endmodule

`default_nettype wire

/* sim/tb_branch_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the branch path top level
module tb_branch_subsys
  import br_pkg::*;
();

  localparam int           W          = OPERAND_WIDTH_DEF;
  localparam logic [W-1:0] RST_PC     = RESET_PC_DEF;
  localparam int           CLK_PERIOD = 40;
  localparam int           NUM_TESTS  = 6;
  // l.nop encoding, major opcode 0x05, never a branch
  localparam logic [31:0]  NOP_INSN   = 32'h1500_0000;

  logic         clk;
  logic         rst;
  logic         flush_i;
  logic         padv_i;
  logic [31:0]  insn_i;
  logic         insn_valid_i;
  logic         flag_i;
  logic [W-1:0] rfb_i;
  logic         except_i;
  logic [W-1:0] except_pc_i;
  logic [W-1:0] pc_o;
  logic         branch_occur_o;
  logic [W-1:0] branch_target_o;

  // Expected redirect schedule, set by the stimulus
  logic         exp_occur;
  logic         exp_occur_q;
  logic [W-1:0] exp_target;
  // Reference fetch PC
  logic [W-1:0] pc_exp;

  int seed            = 17931;
  int errors          = 0;
  int errors_at_start = 0;
  int tests_run       = 0;
  int tests_failed    = 0;

  branch_subsys_top #(
    .OPERAND_WIDTH (W),
    .RESET_PC      (RST_PC)
  ) i_branch_subsys_top (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .padv_i          (padv_i),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .flag_i          (flag_i),
    .rfb_i           (rfb_i),
    .except_i        (except_i),
    .except_pc_i     (except_pc_i),
    .pc_o            (pc_o),
    .branch_occur_o  (branch_occur_o),
    .branch_target_o (branch_target_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fetch rule: load target on a new redirect, else step a word on advance
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_exp      <= RST_PC;
      exp_occur_q <= 1'b0;
    end else begin
      exp_occur_q <= exp_occur;
      if (exp_occur && !exp_occur_q) begin
        pc_exp <= exp_target;
      end else if (padv_i) begin
        pc_exp <= pc_exp + 4;
      end
    end
  end

  task automatic report_error(input string msg);
    errors = errors + 1;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  a_reset_state : assert property (
    @(posedge clk) $fell(rst) |-> (pc_o == RST_PC && !branch_occur_o)
  ) else report_error("pc_o or branch_occur_o wrong at end of reset");

  a_occur : assert property (
    @(posedge clk) disable iff (rst)
    branch_occur_o == exp_occur
  ) else report_error($sformatf("branch_occur_o is %b, expected %b",
                                $sampled(branch_occur_o), $sampled(exp_occur)));

  // Target only meaningful while a redirect is expected
  a_target : assert property (
    @(posedge clk) disable iff (rst)
    exp_occur |-> branch_target_o == exp_target
  ) else report_error($sformatf("branch_target_o is %h, expected %h",
                                $sampled(branch_target_o), $sampled(exp_target)));

  a_pc : assert property (
    @(posedge clk) disable iff (rst)
    pc_o == pc_exp
  ) else report_error($sformatf("pc_o is %h, expected %h",
                                $sampled(pc_o), $sampled(pc_exp)));

  // Immediate branch, decoded at the next edge, redirect one edge later
  task automatic issue_imm(input logic [5:0] opc, input logic flag, input logic taken);
    logic [25:0] imm;
    imm = 26'($random(seed));
    insn_i       <= {opc, imm};
    insn_valid_i <= 1'b1;
    flag_i       <= flag;
    @(posedge clk);
    // pc_exp still holds the issuing PC here
    insn_i     <= NOP_INSN;
    exp_occur  <= taken;
    exp_target <= pc_exp + {{4{imm[25]}}, imm, 2'b00};
    @(posedge clk);
    exp_occur <= 1'b0;
  endtask

  // l.jr enters execute, operand arrives with it
  task automatic issue_jr(input logic [W-1:0] target);
    insn_i       <= {OPC_JR, 26'h0};
    insn_valid_i <= 1'b1;
    @(posedge clk);
    insn_i     <= NOP_INSN;
    rfb_i      <= target;
    exp_occur  <= (target[1:0] == 2'b00);
    exp_target <= target;
    @(posedge clk);
    rfb_i     <= '0;
    exp_occur <= 1'b0;
  endtask

  // Exception lands on top of a pending l.j
  task automatic except_over_imm(input logic [W-1:0] vec);
    insn_i       <= {OPC_J, 26'($random(seed))};
    insn_valid_i <= 1'b1;
    @(posedge clk);
    insn_i      <= NOP_INSN;
    except_i    <= 1'b1;
    except_pc_i <= vec;
    exp_occur   <= 1'b1;
    exp_target  <= vec;
    @(posedge clk);
    except_i  <= 1'b0;
    exp_occur <= 1'b0;
  endtask

  // Flush in the decode cycle kills the l.j
  task automatic flush_imm();
    insn_i       <= {OPC_J, 26'($random(seed))};
    insn_valid_i <= 1'b1;
    flush_i      <= 1'b1;
    @(posedge clk);
    insn_i  <= NOP_INSN;
    flush_i <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  // Tally on the falling edge so assertions of the last edge are in
  task automatic end_test(input string name);
    @(negedge clk);
    tests_run = tests_run + 1;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
    @(posedge clk);
  endtask

  initial begin
    logic [5:0]   opc;
    logic         flag;
    logic [W-1:0] r;
    rst          <= 1'b1;
    flush_i      <= 1'b0;
    padv_i       <= 1'b0;
    insn_i       <= NOP_INSN;
    insn_valid_i <= 1'b0;
    flag_i       <= 1'b0;
    rfb_i        <= '0;
    except_i     <= 1'b0;
    except_pc_i  <= '0;
    exp_occur    <= 1'b0;
    exp_target   <= '0;
    repeat (16) @(posedge clk);
    rst    <= 1'b0;
    padv_i <= 1'b1;
    repeat (2) @(posedge clk);
    end_test("reset state");

    insn_valid_i <= 1'b1;
    repeat (6) @(posedge clk);
    padv_i       <= 1'b0;
    insn_valid_i <= 1'b0;
    repeat (4) @(posedge clk);
    padv_i       <= 1'b1;
    insn_valid_i <= 1'b1;
    repeat (3) @(posedge clk);
    end_test("sequential fetch and stall");

    repeat (4) begin
      issue_imm(OPC_J, 1'($random(seed)), 1'b1);
    end
    end_test("l.j immediate jump");

    // First four cover every flag and opcode pair
    for (int i = 0; i < 8; i++) begin
      opc  = i[0] ? OPC_BF : OPC_BNF;
      flag = (i < 4) ? i[1] : 1'($random(seed));
      issue_imm(opc, flag, (opc == OPC_BF) ? flag : !flag);
    end
    end_test("l.bf and l.bnf");

    repeat (3) begin
      r = $random(seed);
      issue_jr({r[W-1:2], 2'b00});
    end
    repeat (2) begin
      r = $random(seed);
      issue_jr({r[W-1:2], (r[1:0] == 2'b00) ? 2'b10 : r[1:0]});
    end
    end_test("l.jr register jump");

    r = $random(seed);
    except_over_imm({r[W-1:2], 2'b00});
    flush_imm();
    end_test("exception priority and flush");

    $display("Tests run %0d, failed %0d, assertion errors %0d",
             tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
src/br_pkg.sv
src/br_decode_if.sv
src/br_decode.sv
src/br_exec_stage.sv
src/br_ctrl.sv
src/fetch_pc.sv
src/branch_subsys_top.sv
sim/tb_branch_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the branch path testbench with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_branch_subsys \
  -o tb_branch_subsys \
  && (./obj_dir/tb_branch_subsys > sim.log 2>&1; cat sim.log) \
  || { echo "Verilator build failed"; exit 1; }
! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log
